// ==== design/node_defines.svh ====
// node wide constants: broadcast device, register count, set-id address

`ifndef NODE_DEFINES_SVH
`define NODE_DEFINES_SVH

// device value that addresses every node in the chain
`define NODE_BROADCAST 8'hff

// depth of the local register bank
`define NODE_REG_COUNT 16

// address under the system module that selects set-id
`define NODE_SETID_ADDR 8'h00

`endif

// ==== design/node_pkg.sv ====
// node types: module code enum and framer state enum

`default_nettype none

package node_pkg;

	// ------------------------------------------------------------
	// module field of a command
	// ------------------------------------------------------------
	typedef enum logic [7:0] {
		MOD_SYS  = 8'h00,
		MOD_REGS = 8'h01
	} node_mod_e;

	// ------------------------------------------------------------
	// output serializer
	// ------------------------------------------------------------
	typedef enum logic {
		FR_IDLE = 1'b0,
		FR_SEND = 1'b1
	} framer_state_e;

endpackage

`default_nettype wire

// ==== design/cmd_if.sv ====
// command interface: four byte fields, one-cycle valid, source and sink modports

`default_nettype none

interface cmd_if;

	// fields hold only in the vld cycle
	logic [7:0] dev;
	logic [7:0] mod;
	logic [7:0] addr;
	logic [7:0] data;
	logic       vld;

	modport source (
		output dev,
		output mod,
		output addr,
		output data,
		output vld
	);

	modport sink (
		input dev,
		input mod,
		input addr,
		input data,
		input vld
	);

endinterface

`default_nettype wire

// ==== design/cmd_deframer.sv ====
// cmd_deframer: collects four strobed rx bytes into one command pulse

`default_nettype none

module cmd_deframer (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire logic [7:0] rx_byte,
	input  wire logic       rx_strobe,
	input  wire logic       rx_sof,
	cmd_if.source           cmd
);

	// 0 means no frame open, 1..3 bytes collected so far
	logic [2:0] idx;
	logic [7:0] dev_q;
	logic [7:0] mod_q;
	logic [7:0] addr_q;

	// ------------------------------------------------------------
	// byte index and frame tracking
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			idx     <= 3'd0;
			cmd.vld <= 1'b0;
		end else begin
			cmd.vld <= 1'b0;
			if (rx_strobe) begin
				if (rx_sof) begin
					// sof always restarts, even mid-frame
					idx <= 3'd1;
				end else if (idx == 3'd3) begin
					idx     <= 3'd0;
					cmd.vld <= 1'b1;
				end else if (idx != 3'd0) begin
					idx <= idx + 3'd1;
				end
				// no open frame, stray strobe dropped
			end
		end
	end

	// held bytes and assembled command
	always_ff @(posedge clk_sys) begin
		if (rx_strobe) begin
			if (rx_sof) begin
				dev_q <= rx_byte;
			end else if (idx == 3'd1) begin
				mod_q <= rx_byte;
			end else if (idx == 3'd2) begin
				addr_q <= rx_byte;
			end else if (idx == 3'd3) begin
				cmd.dev  <= dev_q;
				cmd.mod  <= mod_q;
				cmd.addr <= addr_q;
				cmd.data <= rx_byte;
			end
		end
	end

	a_idx_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		idx <= 3'd3
	);

endmodule

`default_nettype wire

// ==== design/cmd_router.sv ====
// cmd_router: device id register, local and forward split of commands

`default_nettype none

`include "node_defines.svh"

module cmd_router
	import node_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	cmd_if.sink             cmd_in,
	cmd_if.source           cmd_loc,
	cmd_if.source           cmd_fwd,
	output      logic [7:0] dev_id
);

	logic       broadcast;
	logic       localhost;
	logic       cmd_setid;
	logic [7:0] data_inc;

	assign broadcast = (cmd_in.dev == `NODE_BROADCAST);
	assign localhost = (cmd_in.dev == dev_id);
	assign cmd_setid = broadcast && (cmd_in.mod == MOD_SYS) &&
		(cmd_in.addr == `NODE_SETID_ADDR);
	assign data_inc  = cmd_in.data + 8'd1;

	// ------------------------------------------------------------
	// own id, numbered by the set-id broadcast
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dev_id <= 8'h00;
		end else if (cmd_in.vld && cmd_setid) begin
			dev_id <= data_inc;
		end
	end

	// ------------------------------------------------------------
	// registered outputs, one cycle behind cmd_in
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		cmd_loc.dev  <= cmd_in.dev;
		cmd_loc.mod  <= cmd_in.mod;
		cmd_loc.addr <= cmd_in.addr;
		cmd_loc.data <= cmd_in.data;
		cmd_fwd.dev  <= cmd_in.dev;
		cmd_fwd.mod  <= cmd_in.mod;
		cmd_fwd.addr <= cmd_in.addr;
		// next node downstream numbers itself one higher
		cmd_fwd.data <= cmd_setid ? data_inc : cmd_in.data;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd_loc.vld <= 1'b0;
			cmd_fwd.vld <= 1'b0;
		end else begin
			cmd_loc.vld <= cmd_in.vld && localhost;
			cmd_fwd.vld <= cmd_in.vld && !localhost;
		end
	end

	a_one_path: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(cmd_loc.vld && cmd_fwd.vld)
	);

endmodule

`default_nettype wire

// ==== design/local_reg_bank.sv ====
// local_reg_bank: register writes from local commands, combinational read port

`default_nettype none

`include "node_defines.svh"

module local_reg_bank
	import node_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	cmd_if.sink             cmd,
	input  wire logic [7:0] rd_addr,
	output      logic [7:0] rd_data
);

	localparam int IDX_W = $clog2(`NODE_REG_COUNT);

	logic [7:0] regs [`NODE_REG_COUNT];
	logic       wr_en;

	// only the register module with an in-range address writes
	assign wr_en = cmd.vld && (cmd.mod == MOD_REGS) &&
		(cmd.addr < 8'(`NODE_REG_COUNT));

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NODE_REG_COUNT; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (wr_en) begin
			regs[cmd.addr[IDX_W-1:0]] <= cmd.data;
		end
	end

	// ------------------------------------------------------------
	// read side, zero outside the bank
	// ------------------------------------------------------------
	always_comb begin
		if (rd_addr < 8'(`NODE_REG_COUNT)) begin
			rd_data = regs[rd_addr[IDX_W-1:0]];
		end else begin
			rd_data = 8'h00;
		end
	end

endmodule

`default_nettype wire

// ==== design/cmd_framer.sv ====
// cmd_framer: serializes a forwarded command into four tx byte strobes

`default_nettype none

module cmd_framer
	import node_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	cmd_if.sink             cmd,
	output      logic [7:0] tx_byte,
	output      logic       tx_strobe,
	output      logic       tx_sof
);

	framer_state_e state;
	// index of the next byte to put out
	logic [1:0]    cnt;
	logic [7:0]    mod_q;
	logic [7:0]    addr_q;
	logic [7:0]    data_q;

	// ------------------------------------------------------------
	// state machine and strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= FR_IDLE;
			cnt       <= 2'd0;
			tx_strobe <= 1'b0;
			tx_sof    <= 1'b0;
		end else if (cmd.vld) begin
			// device byte goes out straight from the load
			state     <= FR_SEND;
			cnt       <= 2'd1;
			tx_strobe <= 1'b1;
			tx_sof    <= 1'b1;
		end else if (state == FR_SEND) begin
			tx_strobe <= 1'b1;
			tx_sof    <= 1'b0;
			cnt       <= cnt + 2'd1;
			if (cnt == 2'd3) begin
				state <= FR_IDLE;
			end
		end else begin
			tx_strobe <= 1'b0;
			tx_sof    <= 1'b0;
		end
	end

	// latched command and byte mux
	always_ff @(posedge clk_sys) begin
		if (cmd.vld) begin
			mod_q   <= cmd.mod;
			addr_q  <= cmd.addr;
			data_q  <= cmd.data;
			tx_byte <= cmd.dev;
		end else if (state == FR_SEND) begin
			case (cnt)
				2'd1:    tx_byte <= mod_q;
				2'd2:    tx_byte <= addr_q;
				default: tx_byte <= data_q;
			endcase
		end
	end

	// rx byte spacing keeps loads out of a running frame
	a_no_overrun: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		cmd.vld |-> state == FR_IDLE
	);

endmodule

`default_nettype wire

// ==== design/node_chain_top.sv ====
// node_chain_top: deframer, router, register bank and framer of one chain node

`default_nettype none

module node_chain_top (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire logic [7:0] rx_byte,
	input  wire logic       rx_strobe,
	input  wire logic       rx_sof,
	output      logic [7:0] tx_byte,
	output      logic       tx_strobe,
	output      logic       tx_sof,
	output      logic [7:0] dev_id,
	input  wire logic [7:0] rd_addr,
	output      logic [7:0] rd_data
);

	cmd_if cmd_rx ();
	cmd_if cmd_loc ();
	cmd_if cmd_fwd ();

	// ------------------------------------------------------------
	// input side
	// ------------------------------------------------------------
	cmd_deframer u_cmd_deframer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_sof    (rx_sof),
		.cmd       (cmd_rx.source)
	);

	cmd_router u_cmd_router (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cmd_in  (cmd_rx.sink),
		.cmd_loc (cmd_loc.source),
		.cmd_fwd (cmd_fwd.source),
		.dev_id  (dev_id)
	);

	// ------------------------------------------------------------
	// output side
	// ------------------------------------------------------------
	local_reg_bank u_local_reg_bank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cmd     (cmd_loc.sink),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	cmd_framer u_cmd_framer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cmd       (cmd_fwd.sink),
		.tx_byte   (tx_byte),
		.tx_strobe (tx_strobe),
		.tx_sof    (tx_sof)
	);

endmodule

`default_nettype wire

// ==== bench/node_chain_tb.sv ====
// node_chain_tb: vector driven rx stimulus, tx monitor, dev_id and register checks

`default_nettype none

module node_chain_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam string VEC_FILE = "bench/node_chain_vectors.txt";
	localparam int    REG_COUNT = 16;

	logic       clk_sys;
	logic       rst_n;
	logic [7:0] rx_byte;
	logic       rx_strobe;
	logic       rx_sof;
	logic [7:0] tx_byte;
	logic       tx_strobe;
	logic       tx_sof;
	logic [7:0] dev_id;
	logic [7:0] rd_addr;
	logic [7:0] rd_data;

	// parsed vector lines, fields packed high byte first
	byte         vec_kind [$];
	logic [55:0] vec_field [$];
	// expected tx stream as {sof, byte} and the cycle each byte is due in
	logic [8:0]  tx_exp [$];
	int          tx_due [$];
	// pending dev_id checks and the cycle each is due in
	logic [7:0]  id_exp [$];
	int          id_due [$];
	// register contents expected from the local writes so far
	logic [7:0]  reg_exp [REG_COUNT] = '{default: 8'h00};
	int          cycle_count = 0;
	int          cycle_limit = 0;

	node_chain_top u_node_chain_top (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_sof    (rx_sof),
		.tx_byte   (tx_byte),
		.tx_strobe (tx_strobe),
		.tx_sof    (tx_sof),
		.dev_id    (dev_id),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	always #5 clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// failure and compare helpers
	// ------------------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic load_vectors();
		int         fd;
		int         cnt;
		string      line;
		logic [7:0] v [7];
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			fail_run("could not open the vector file bench/node_chain_vectors.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] == "C") begin
				cnt = $sscanf(line, "C %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
				if (cnt != 7) begin
					fail_run({"malformed command line in vector file: ", line});
				end
				vec_kind.push_back("C");
				vec_field.push_back({v[0], v[1], v[2], v[3], v[4], v[5], v[6]});
			end else if (line.len() > 0 && line[0] == "R") begin
				cnt = $sscanf(line, "R %h %h", v[0], v[1]);
				if (cnt != 2) begin
					fail_run({"malformed readback line in vector file: ", line});
				end
				vec_kind.push_back("R");
				vec_field.push_back({v[0], v[1], 40'd0});
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------
	// rx drive, one byte or idle cycle per falling edge
	// ------------------------------------------------------------
	task automatic drive_byte(input logic [7:0] b, input logic sof);
		@(negedge clk_sys);
		rx_byte   = b;
		rx_strobe = 1'b1;
		rx_sof    = sof;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			rx_strobe = 1'b0;
			rx_sof    = 1'b0;
		end
	endtask

	task automatic send_cmd(input int n, input logic [55:0] f);
		int gap;
		int base;
		if (n % 4 == 1) begin
			// stray strobes, no frame open
			drive_byte(8'($urandom), 1'b0);
			drive_byte(8'($urandom), 1'b0);
		end else if (n % 4 == 2) begin
			// partial frame, cut short by the real sof
			drive_byte(8'($urandom), 1'b1);
			drive_byte(8'($urandom), 1'b0);
		end
		drive_byte(f[55:48], 1'b1);
		drive_byte(f[47:40], 1'b0);
		drive_byte(f[39:32], 1'b0);
		drive_byte(f[31:24], 1'b0);
		base = cycle_count;
		// id register settles two edges after the data byte
		id_exp.push_back(f[7:0]);
		id_due.push_back(base + 2);
		if (f[23:16] != 8'h00) begin
			// first tx byte one edge after the router output, then three more
			tx_exp.push_back({1'b1, f[55:48]});
			tx_exp.push_back({1'b0, f[47:40]});
			tx_exp.push_back({1'b0, f[39:32]});
			tx_exp.push_back({1'b0, f[15:8]});
			for (int k = 3; k < 7; k++) begin
				tx_due.push_back(base + k);
			end
		end else if (f[47:40] == 8'h01 && f[39:32] < REG_COUNT) begin
			reg_exp[f[35:32]] = f[31:24];
		end
		// n = 3 mod 4 runs straight into the next frame
		gap = (n % 4 == 3) ? 0 : int'($urandom % 4);
		idle(gap);
	endtask

	task automatic read_reg(input logic [55:0] f);
		idle(4);
		rd_addr = f[55:48];
		idle(1);
		compare("rd_data", rd_data, f[47:40]);
	endtask

	// whole bank against the writes seen, catches aliased out of range writes
	task automatic sweep_regs();
		for (int a = 0; a < REG_COUNT; a++) begin
			rd_addr = 8'(a);
			idle(1);
			compare("rd_data", rd_data, reg_exp[a]);
		end
	endtask

	// ------------------------------------------------------------
	// tx monitor, id checks, cycle limit
	// ------------------------------------------------------------
	always @(negedge clk_sys) begin
		if (tx_due.size() != 0 && tx_due[0] == cycle_count) begin
			if (!tx_strobe) begin
				fail_run("tx strobe missing in a cycle that should carry a forwarded byte");
			end else begin
				compare("tx_byte", tx_byte, tx_exp[0][7:0]);
				compare("tx_sof", {7'd0, tx_sof}, {7'd0, tx_exp[0][8]});
				void'(tx_exp.pop_front());
				void'(tx_due.pop_front());
			end
		end else if (tx_strobe) begin
			fail_run("tx strobe seen while no forwarded byte was expected");
		end
		if (id_due.size() != 0 && id_due[0] == cycle_count) begin
			compare("dev_id", dev_id, id_exp[0]);
			void'(id_exp.pop_front());
			void'(id_due.pop_front());
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			fail_run("timeout: the vectors did not finish within the cycle limit");
		end
	end

	initial begin
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		rx_byte   = 8'h00;
		rx_strobe = 1'b0;
		rx_sof    = 1'b0;
		rd_addr   = 8'h00;
		void'($urandom(32'ha740_38ea));
		load_vectors();
		cycle_limit = vec_kind.size() * 12 + 50;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		compare("dev_id", dev_id, 8'h00);
		for (int i = 0; i < vec_kind.size(); i++) begin
			if (vec_kind[i] == "C") begin
				send_cmd(i, vec_field[i]);
			end else begin
				read_reg(vec_field[i]);
			end
		end
		idle(10);
		sweep_regs();
		if (tx_exp.size() != 0 || id_exp.size() != 0) begin
			fail_run("run ended with forwarded bytes or id checks still outstanding");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== node_chain_top.f ====
+incdir+design
design/node_pkg.sv
design/cmd_if.sv
design/cmd_deframer.sv
design/cmd_router.sv
design/local_reg_bank.sv
design/cmd_framer.sv
design/node_chain_top.sv
bench/node_chain_tb.sv

// ==== Makefile ====
# Verilator build and run of the node chain testbench

VERILATOR ?= verilator
TOP       ?= node_chain_tb
FILELIST  ?= node_chain_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/node_chain_vectors.txt ====
# command line: C dev mod addr data exp_fwd exp_data exp_id (exp_data is the 4th tx byte)
# readback line: R addr exp_value, all fields hex
C ff 00 00 04 1 05 05
R 00 00
C 05 01 03 a5 0 00 05
R 03 a5
C 07 01 02 3c 1 3c 05
C 05 01 10 77 0 00 05
R 10 00
C 05 01 0f 5a 0 00 05
R 0f 5a
C 05 00 02 11 0 00 05
R 02 00
C ff 01 00 20 1 20 05
C 00 01 01 99 1 99 05
C ff 00 00 09 1 0a 0a
C 0a 01 01 c3 0 00 0a
R 01 c3
R 03 a5
C 05 01 04 44 1 44 0a
